// File: source/sched_pkg.sv
package sched_pkg;

  // Field widths fixed by the 36-bit control message format
  localparam int HASH_WIDTH     = 32;
  localparam int CTRL_WIDTH     = 36;
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int CORE_ID_WIDTH  = 4;
  localparam int SLOT_WIDTH     = 4;

  // Types 1 and 2 belong to inter-core traffic and are only swallowed here
  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_RETURN = 4'd0,
    MSG_PKT_DONE    = 4'd1,
    MSG_PKT_TO_CORE = 4'd2,
    MSG_SLOT_INIT   = 4'd3
  } msg_type_e;

  // Type on top, slot field at bits 19:16, the rest is opaque descriptor
  typedef struct packed {
    msg_type_e                                 msg_type;
    logic [CTRL_WIDTH-MSG_TYPE_WIDTH-21:0]     desc_hi;
    logic [SLOT_WIDTH-1:0]                     slot;
    logic [15:0]                               desc_lo;
  } ctrl_msg_t;

  typedef struct packed {
    logic [HASH_WIDTH-1:0] value;
  } flow_hash_t;

  typedef struct packed {
    logic                     drop;
    logic [HASH_WIDTH-1:0]    hash;
    logic [CORE_ID_WIDTH-1:0] core;
    logic [SLOT_WIDTH-1:0]    slot;
  } rx_desc_t;

  // APB register map, one 32-bit word per entry
  localparam int APB_ADDR_WIDTH = 8;

  localparam logic [APB_ADDR_WIDTH-1:0] REG_CORE_EN   = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_DROP_BASE = 8'h10;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_SLOT_BASE = 8'h40;

endpackage

// File: source/sched_fifo.sv
`timescale 1ns/1ns

module sched_fifo #(
  parameter int  FIFO_DEPTH = 4,
  parameter type payload_t  = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_r,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  payload_t             mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 push;
  logic                 pop;

  // Wrap explicitly so any depth works, not only powers of two
  function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
    if (int'(ptr) == FIFO_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready  = (count != (PTR_WIDTH + 1)'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

// File: source/ctrl_msg_decoder.sv
`timescale 1ns/1ns

module ctrl_msg_decoder import sched_pkg::*; #(
  parameter int CORE_COUNT = 16
) (
  input  logic                     clk,
  input  logic                     rst_r,
  input  logic                     ctrl_valid,
  output logic                     ctrl_ready,
  input  ctrl_msg_t                ctrl,
  input  logic [CORE_ID_WIDTH-1:0] ctrl_src,
  output logic [CORE_COUNT-1:0]    slot_return,
  output logic [CORE_COUNT-1:0]    slot_init,
  output logic [SLOT_WIDTH-1:0]    slot_value
);

  logic [CORE_COUNT-1:0] src_onehot;
  logic                  is_return;
  logic                  is_init;

  // Every message type is consumed at once, unknown ones simply vanish
  assign ctrl_ready = 1'b1;

  // Sources beyond CORE_COUNT shift out and select no core
  assign src_onehot = CORE_COUNT'(1) << ctrl_src;

  assign is_return = ctrl_valid && (ctrl.msg_type == MSG_SLOT_RETURN);
  assign is_init   = ctrl_valid && (ctrl.msg_type == MSG_SLOT_INIT);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      slot_return <= '0;
      slot_init   <= '0;
    end else begin
      slot_return <= is_return ? src_onehot : '0;
      slot_init   <= is_init ? src_onehot : '0;
    end
  end

  // Slot number for a return, slot budget for an init
  always_ff @(posedge clk) begin
    if (ctrl_valid) begin
      slot_value <= ctrl.slot;
    end
  end

endmodule

// File: source/slot_keeper.sv
`timescale 1ns/1ns

module slot_keeper import sched_pkg::*; #(
  parameter int SLOT_COUNT = 8
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  init_valid,
  input  logic                  slot_return_valid,
  input  logic [SLOT_WIDTH-1:0] slot_in,
  input  logic                  pop,
  output logic [SLOT_WIDTH-1:0] slot_out,
  output logic                  slot_avail,
  output logic [SLOT_WIDTH-1:0] slot_count
);

  localparam int PTR_WIDTH = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;

  logic [SLOT_WIDTH-1:0] slots [SLOT_COUNT];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [SLOT_WIDTH-1:0] count;
  logic [SLOT_WIDTH-1:0] init_n;
  logic                  do_return;
  logic                  do_pop;

  function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
    if (int'(ptr) == SLOT_COUNT - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Budget larger than the queue gets clamped
  assign init_n = (int'(slot_in) > SLOT_COUNT) ? SLOT_WIDTH'(SLOT_COUNT) : slot_in;

  assign do_return = slot_return_valid && (int'(count) != SLOT_COUNT);
  assign do_pop    = pop && (count != '0);

  assign slot_out   = slots[rd_ptr];
  assign slot_avail = (count != '0);
  assign slot_count = count;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= (int'(init_n) == SLOT_COUNT) ? '0 : PTR_WIDTH'(init_n);
      count  <= init_n;
    end else begin
      if (do_return) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count <= count + SLOT_WIDTH'(do_return) - SLOT_WIDTH'(do_pop);
    end
  end

  // Init lays out slots in order; only the first n are live
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slots[i] <= SLOT_WIDTH'(i);
      end
    end else if (do_return) begin
      slots[wr_ptr] <= slot_in;
    end
  end

endmodule

// File: source/rx_desc_allocator.sv
`timescale 1ns/1ns

module rx_desc_allocator import sched_pkg::*; #(
  parameter int INTERFACE_COUNT = 3,
  parameter int CORE_COUNT      = 16,
  parameter int SLOT_COUNT      = 8
) (
  input  logic                       clk,
  input  logic                       rst_r,
  input  logic [INTERFACE_COUNT-1:0] hash_valid,
  output logic [INTERFACE_COUNT-1:0] hash_pop,
  input  flow_hash_t                 hash [INTERFACE_COUNT],
  output logic [INTERFACE_COUNT-1:0] desc_push,
  input  logic [INTERFACE_COUNT-1:0] desc_ready,
  output rx_desc_t                   desc,
  input  logic [CORE_COUNT-1:0]      slot_return,
  input  logic [CORE_COUNT-1:0]      slot_init,
  input  logic [SLOT_WIDTH-1:0]      slot_value,
  input  logic [CORE_COUNT-1:0]      core_en,
  output logic [31:0]                drop_count [INTERFACE_COUNT],
  output logic [SLOT_WIDTH-1:0]      slot_count [CORE_COUNT]
);

  localparam int IF_IDX_WIDTH = (INTERFACE_COUNT > 1) ? $clog2(INTERFACE_COUNT) : 1;

  logic [INTERFACE_COUNT-1:0] req;
  logic [INTERFACE_COUNT-1:0] grant;
  logic [IF_IDX_WIDTH-1:0]    grant_idx;
  logic                       grant_valid;
  logic [INTERFACE_COUNT-1:0] grant_r;
  logic [IF_IDX_WIDTH-1:0]    grant_idx_r;
  logic                       grant_valid_r;
  logic [IF_IDX_WIDTH-1:0]    last_idx;
  logic [CORE_ID_WIDTH-1:0]   core_r;
  logic [CORE_COUNT-1:0]      slot_avail;
  logic [SLOT_WIDTH-1:0]      slot_out [CORE_COUNT];
  logic [CORE_COUNT-1:0]      slot_pop;
  logic                       core_ok;

  // Last cycle's winner is still being decided, so it sits this one out
  assign req = hash_valid & desc_ready & ~grant_r;

  // Round robin, searching from the interface after the previous winner
  always_comb begin
    int cand;
    grant       = '0;
    grant_idx   = last_idx;
    grant_valid = 1'b0;
    for (int i = 1; i <= INTERFACE_COUNT; i++) begin
      cand = (int'(last_idx) + i) % INTERFACE_COUNT;
      if (!grant_valid && req[cand]) begin
        grant[cand] = 1'b1;
        grant_idx   = IF_IDX_WIDTH'(cand);
        grant_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_r       <= '0;
      grant_idx_r   <= '0;
      grant_valid_r <= 1'b0;
      last_idx      <= IF_IDX_WIDTH'(INTERFACE_COUNT - 1);
      core_r        <= '0;
    end else begin
      grant_r       <= grant;
      grant_idx_r   <= grant_idx;
      grant_valid_r <= grant_valid;
      // Target core comes straight from the low hash bits
      core_r        <= hash[grant_idx].value[CORE_ID_WIDTH-1:0];
      if (grant_valid) begin
        last_idx <= grant_idx;
      end
    end
  end

  // Decision cycle: the granted hash is still at its FIFO head
  assign core_ok = grant_valid_r && (int'(core_r) < CORE_COUNT) &&
                   core_en[core_r] && slot_avail[core_r];

  assign hash_pop  = grant_r;
  assign desc_push = grant_r;
  assign slot_pop  = core_ok ? (CORE_COUNT'(1) << core_r) : '0;

  always_comb begin
    desc.drop = !core_ok;
    desc.hash = hash[grant_idx_r].value;
    desc.core = core_r;
    desc.slot = core_ok ? slot_out[core_r] : '0;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int i = 0; i < INTERFACE_COUNT; i++) begin
        drop_count[i] <= '0;
      end
    end else if (grant_valid_r && !core_ok) begin
      drop_count[grant_idx_r] <= drop_count[grant_idx_r] + 32'd1;
    end
  end

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    slot_keeper #(
      .SLOT_COUNT (SLOT_COUNT)
    ) i_slot_keeper (
      .clk               (clk),
      .rst_r             (rst_r),
      .init_valid        (slot_init[c]),
      .slot_return_valid (slot_return[c]),
      .slot_in           (slot_value),
      .pop               (slot_pop[c]),
      .slot_out          (slot_out[c]),
      .slot_avail        (slot_avail[c]),
      .slot_count        (slot_count[c])
    );
  end

endmodule

// File: source/sched_status_apb.sv
`timescale 1ns/1ns

module sched_status_apb import sched_pkg::*; #(
  parameter int INTERFACE_COUNT = 3,
  parameter int CORE_COUNT      = 16
) (
  input  logic                      clk,
  input  logic                      rst_r,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic [CORE_COUNT-1:0]     core_en,
  input  logic [31:0]               drop_count [INTERFACE_COUNT],
  input  logic [SLOT_WIDTH-1:0]     slot_count [CORE_COUNT]
);

  logic wr_en;

  // No wait states
  assign pready = 1'b1;

  assign wr_en = psel && penable && pwrite;

  // All cores start disabled until the host opens them
  always_ff @(posedge clk) begin
    if (rst_r) begin
      core_en <= '0;
    end else if (wr_en && (paddr == REG_CORE_EN)) begin
      core_en <= pwdata[CORE_COUNT-1:0];
    end
  end

  // Read mux, every source is already a register
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (paddr == REG_CORE_EN) begin
        prdata = 32'(core_en);
      end
      for (int i = 0; i < INTERFACE_COUNT; i++) begin
        if (paddr == APB_ADDR_WIDTH'(REG_DROP_BASE + 4 * i)) begin
          prdata = drop_count[i];
        end
      end
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (paddr == APB_ADDR_WIDTH'(REG_SLOT_BASE + 4 * c)) begin
          prdata = 32'(slot_count[c]);
        end
      end
    end
  end

endmodule

// File: source/rx_scheduler.sv
`timescale 1ns/1ns

module rx_scheduler import sched_pkg::*; #(
  parameter int INTERFACE_COUNT = 3,
  parameter int CORE_COUNT      = 16,
  parameter int SLOT_COUNT      = 8,
  parameter int FIFO_DEPTH      = 4
) (
  input  logic                       clk,
  input  logic                       rst_r,
  // Flow hashes from the Ethernet interfaces
  input  logic [INTERFACE_COUNT-1:0] hash_valid,
  output logic [INTERFACE_COUNT-1:0] hash_ready,
  input  flow_hash_t                 hash [INTERFACE_COUNT],
  // Descriptors back out per interface
  output logic [INTERFACE_COUNT-1:0] desc_valid,
  input  logic [INTERFACE_COUNT-1:0] desc_ready,
  output rx_desc_t                   desc [INTERFACE_COUNT],
  // Control messages from the cores
  input  logic                       ctrl_valid,
  output logic                       ctrl_ready,
  input  ctrl_msg_t                  ctrl,
  input  logic [CORE_ID_WIDTH-1:0]   ctrl_src,
  // Host status port
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [APB_ADDR_WIDTH-1:0]  paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready
);

  logic [INTERFACE_COUNT-1:0] hash_f_valid;
  logic [INTERFACE_COUNT-1:0] hash_f_pop;
  flow_hash_t                 hash_f [INTERFACE_COUNT];
  logic [INTERFACE_COUNT-1:0] desc_push;
  logic [INTERFACE_COUNT-1:0] desc_in_ready;
  rx_desc_t                   desc_in;
  logic [CORE_COUNT-1:0]      slot_return;
  logic [CORE_COUNT-1:0]      slot_init;
  logic [SLOT_WIDTH-1:0]      slot_value;
  logic [CORE_COUNT-1:0]      core_en;
  logic [31:0]                drop_count [INTERFACE_COUNT];
  logic [SLOT_WIDTH-1:0]      slot_count [CORE_COUNT];

  for (genvar i = 0; i < INTERFACE_COUNT; i++) begin : g_intf
    sched_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .payload_t  (flow_hash_t)
    ) i_hash_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (hash_valid[i]),
      .in_ready  (hash_ready[i]),
      .in_data   (hash[i]),
      .out_valid (hash_f_valid[i]),
      .out_ready (hash_f_pop[i]),
      .out_data  (hash_f[i])
    );

    // One descriptor bus from the allocator, pushed into the granted FIFO
    sched_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .payload_t  (rx_desc_t)
    ) i_desc_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (desc_push[i]),
      .in_ready  (desc_in_ready[i]),
      .in_data   (desc_in),
      .out_valid (desc_valid[i]),
      .out_ready (desc_ready[i]),
      .out_data  (desc[i])
    );
  end

  ctrl_msg_decoder #(
    .CORE_COUNT (CORE_COUNT)
  ) i_ctrl_msg_decoder (
    .clk         (clk),
    .rst_r       (rst_r),
    .ctrl_valid  (ctrl_valid),
    .ctrl_ready  (ctrl_ready),
    .ctrl        (ctrl),
    .ctrl_src    (ctrl_src),
    .slot_return (slot_return),
    .slot_init   (slot_init),
    .slot_value  (slot_value)
  );

  rx_desc_allocator #(
    .INTERFACE_COUNT (INTERFACE_COUNT),
    .CORE_COUNT      (CORE_COUNT),
    .SLOT_COUNT      (SLOT_COUNT)
  ) i_rx_desc_allocator (
    .clk         (clk),
    .rst_r       (rst_r),
    .hash_valid  (hash_f_valid),
    .hash_pop    (hash_f_pop),
    .hash        (hash_f),
    .desc_push   (desc_push),
    .desc_ready  (desc_in_ready),
    .desc        (desc_in),
    .slot_return (slot_return),
    .slot_init   (slot_init),
    .slot_value  (slot_value),
    .core_en     (core_en),
    .drop_count  (drop_count),
    .slot_count  (slot_count)
  );

  sched_status_apb #(
    .INTERFACE_COUNT (INTERFACE_COUNT),
    .CORE_COUNT      (CORE_COUNT)
  ) i_sched_status_apb (
    .clk        (clk),
    .rst_r      (rst_r),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .core_en    (core_en),
    .drop_count (drop_count),
    .slot_count (slot_count)
  );

endmodule

// File: dv/rx_scheduler_tb.sv
`timescale 1ns/1ns

module rx_scheduler_tb import sched_pkg::*; ();

  localparam int INTERFACE_COUNT = 3;
  localparam int CORE_COUNT      = 16;
  localparam int SLOT_COUNT      = 8;
  localparam int FIFO_DEPTH      = 4;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_CTRL, OP_HASH, OP_DRAIN} op_e;

  // Ctrl rows use msg, src and slot
  // Hash rows use intf, data, slot and drop, with the expected core in src
  typedef struct packed {
    op_e         op;
    logic [1:0]  intf;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [4:0]  rep;
    logic [3:0]  msg;
    logic [3:0]  src;
    logic [3:0]  slot;
    logic        drop;
  } step_t;

  localparam int NUM_STEPS  = 50;
  localparam int MAX_CYCLES = 40 * NUM_STEPS + 200;

  localparam step_t STEPS [NUM_STEPS] = '{
    // Reset values and a hash to a disabled core
    '{OP_RD,    2'd0, 8'h00, 32'h0000_0000, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h10, 32'h0000_0000, 5'd3,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h40, 32'h0000_0000, 5'd16, 4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_HASH,  2'd1, 8'h00, 32'h0000_1237, 5'd0,  4'd0, 4'd7,  4'd0, 1'b1},
    '{OP_DRAIN, 2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h14, 32'h0000_0001, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    // Enable cores 2, 5, 9 and 12 and give core 5 a budget of 3
    '{OP_WR,    2'd0, 8'h00, 32'h0000_1224, 5'd0,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h00, 32'h0000_1224, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd3, 4'd5,  4'd3, 1'b0},
    '{OP_RD,    2'd0, 8'h54, 32'h0000_0003, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_HASH,  2'd0, 8'h00, 32'h5A5A_0015, 5'd0,  4'd0, 4'd5,  4'd0, 1'b0},
    '{OP_HASH,  2'd0, 8'h00, 32'h7E31_00A5, 5'd0,  4'd0, 4'd5,  4'd1, 1'b0},
    '{OP_HASH,  2'd0, 8'h00, 32'h0BAD_F005, 5'd0,  4'd0, 4'd5,  4'd2, 1'b0},
    '{OP_HASH,  2'd0, 8'h00, 32'h9C3D_4E25, 5'd0,  4'd0, 4'd5,  4'd0, 1'b1},
    '{OP_DRAIN, 2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h54, 32'h0000_0000, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h10, 32'h0000_0001, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    // Return slot 1 and hand it out again
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd0, 4'd5,  4'd1, 1'b0},
    '{OP_RD,    2'd0, 8'h54, 32'h0000_0001, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_HASH,  2'd2, 8'h00, 32'h3141_5925, 5'd0,  4'd0, 4'd5,  4'd1, 1'b0},
    '{OP_DRAIN, 2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h54, 32'h0000_0000, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    // Types 1 and 2 leave the queue alone
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd3, 4'd5,  4'd4, 1'b0},
    '{OP_RD,    2'd0, 8'h54, 32'h0000_0004, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd1, 4'd5,  4'd2, 1'b0},
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd2, 4'd5,  4'd7, 1'b0},
    '{OP_RD,    2'd0, 8'h54, 32'h0000_0004, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_HASH,  2'd1, 8'h00, 32'h2718_2815, 5'd0,  4'd0, 4'd5,  4'd0, 1'b0},
    '{OP_DRAIN, 2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h54, 32'h0000_0003, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    // All three interfaces at once with one core each
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd3, 4'd2,  4'd3, 1'b0},
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd3, 4'd9,  4'd3, 1'b0},
    '{OP_CTRL,  2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd3, 4'd12, 4'd2, 1'b0},
    '{OP_HASH,  2'd0, 8'h00, 32'h1000_0002, 5'd0,  4'd0, 4'd2,  4'd0, 1'b0},
    '{OP_HASH,  2'd1, 8'h00, 32'h2000_0019, 5'd0,  4'd0, 4'd9,  4'd0, 1'b0},
    '{OP_HASH,  2'd2, 8'h00, 32'h3000_002C, 5'd0,  4'd0, 4'd12, 4'd0, 1'b0},
    '{OP_HASH,  2'd0, 8'h00, 32'h4000_0032, 5'd0,  4'd0, 4'd2,  4'd1, 1'b0},
    '{OP_HASH,  2'd1, 8'h00, 32'h5000_0049, 5'd0,  4'd0, 4'd9,  4'd1, 1'b0},
    '{OP_HASH,  2'd2, 8'h00, 32'h6000_005C, 5'd0,  4'd0, 4'd12, 4'd1, 1'b0},
    '{OP_HASH,  2'd0, 8'h00, 32'h7000_0062, 5'd0,  4'd0, 4'd2,  4'd2, 1'b0},
    '{OP_HASH,  2'd1, 8'h00, 32'h8000_0079, 5'd0,  4'd0, 4'd9,  4'd2, 1'b0},
    '{OP_HASH,  2'd2, 8'h00, 32'h9000_008C, 5'd0,  4'd0, 4'd12, 4'd0, 1'b1},
    '{OP_HASH,  2'd0, 8'h00, 32'hA000_0092, 5'd0,  4'd0, 4'd2,  4'd0, 1'b1},
    '{OP_DRAIN, 2'd0, 8'h00, 32'h0000_0000, 5'd0,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h10, 32'h0000_0002, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h14, 32'h0000_0001, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h18, 32'h0000_0001, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h48, 32'h0000_0000, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h64, 32'h0000_0000, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0},
    '{OP_RD,    2'd0, 8'h70, 32'h0000_0000, 5'd1,  4'd0, 4'd0,  4'd0, 1'b0}
  };

  logic                       clk = 1'b0;
  logic                       rst_r = 1'b1;
  logic [INTERFACE_COUNT-1:0] hash_valid = '0;
  logic [INTERFACE_COUNT-1:0] hash_ready;
  flow_hash_t                 hash [INTERFACE_COUNT] = '{default: '0};
  logic [INTERFACE_COUNT-1:0] desc_valid;
  logic [INTERFACE_COUNT-1:0] desc_ready = '0;
  rx_desc_t                   desc [INTERFACE_COUNT];
  logic                       ctrl_valid = 1'b0;
  logic                       ctrl_ready;
  ctrl_msg_t                  ctrl = '0;
  logic [CORE_ID_WIDTH-1:0]   ctrl_src = '0;
  logic                       psel = 1'b0;
  logic                       penable = 1'b0;
  logic                       pwrite = 1'b0;
  logic [APB_ADDR_WIDTH-1:0]  paddr = '0;
  logic [31:0]                pwdata = '0;
  logic [31:0]                prdata;
  logic                       pready;
  logic [15:0]                lfsr_state = 16'd72;
  int                         cycle_count = 0;
  rx_desc_t                   exp_q [INTERFACE_COUNT][$];

  rx_scheduler #(
    .INTERFACE_COUNT (INTERFACE_COUNT),
    .CORE_COUNT      (CORE_COUNT),
    .SLOT_COUNT      (SLOT_COUNT),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) i_dut (
    .clk        (clk),
    .rst_r      (rst_r),
    .hash_valid (hash_valid),
    .hash_ready (hash_ready),
    .hash       (hash),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc       (desc),
    .ctrl_valid (ctrl_valid),
    .ctrl_ready (ctrl_ready),
    .ctrl       (ctrl),
    .ctrl_src   (ctrl_src),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready)
  );

  always #10 clk = ~clk;

  task automatic report_error(input string line);
    $display("%s", line);
    $display("Regression failed");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got == want) else begin
      report_error($sformatf("FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                             $time, name, got, want));
      $fatal(1, "run stopped at first error");
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  // Ready needs two set LFSR bits per interface
  always @(posedge clk) begin
    logic [15:0]                state;
    logic [INTERFACE_COUNT-1:0] ready_next;
    state = lfsr_state;
    for (int i = 0; i < INTERFACE_COUNT; i++) begin
      state = lfsr_next(state);
      ready_next[i] = state[0];
      state = lfsr_next(state);
      ready_next[i] = ready_next[i] & state[0];
    end
    lfsr_state <= state;
    desc_ready <= rst_r ? '0 : ready_next;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    assert (cycle_count < MAX_CYCLES) else begin
      report_error($sformatf("Timeout: the test did not end within %0d cycles", MAX_CYCLES));
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // Descriptor transfers are sampled at the falling edge
  always @(negedge clk) begin
    rx_desc_t want;
    if (!rst_r) begin
      for (int i = 0; i < INTERFACE_COUNT; i++) begin
        if (desc_valid[i] && desc_ready[i]) begin
          assert (exp_q[i].size() > 0) else begin
            report_error($sformatf("Interface %0d sent a descriptor that was not expected", i));
            $fatal(1, "run stopped at first error");
          end
          want = exp_q[i].pop_front();
          check_value($sformatf("desc[%0d].drop", i), 32'(desc[i].drop), 32'(want.drop));
          check_value($sformatf("desc[%0d].hash", i), desc[i].hash, want.hash);
          check_value($sformatf("desc[%0d].core", i), 32'(desc[i].core), 32'(want.core));
          // Slot number is meaningless on a drop
          if (!want.drop) begin
            check_value($sformatf("desc[%0d].slot", i), 32'(desc[i].slot), 32'(want.slot));
          end
        end
      end
    end
  end

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] want);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    assert (pready) else begin
      report_error("APB slave held pready low in the access phase");
      $fatal(1, "run stopped at first error");
    end
    check_value($sformatf("prdata[0x%02h]", addr), prdata, want);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic send_ctrl(input logic [3:0] msg_code, input logic [3:0] src,
                           input logic [3:0] slot);
    ctrl_msg_t msg;
    msg          = '0;
    msg.msg_type = msg_type_e'(msg_code);
    msg.slot     = slot;
    msg.desc_lo  = 16'hC0DE;
    @(posedge clk);
    ctrl_valid <= 1'b1;
    ctrl       <= msg;
    ctrl_src   <= src;
    @(negedge clk);
    assert (ctrl_ready) else begin
      report_error("Control message input did not accept a message");
      $fatal(1, "run stopped at first error");
    end
    @(posedge clk);
    ctrl_valid <= 1'b0;
    // Strobe follows the transfer by a cycle and the queue updates on the edge after
    repeat (2) @(posedge clk);
  endtask

  task automatic send_hash(input logic [1:0] intf, input logic [31:0] value,
                           input logic [3:0] core, input logic [3:0] slot,
                           input logic drop);
    rx_desc_t want;
    want.drop = drop;
    want.hash = value;
    want.core = core;
    want.slot = drop ? '0 : slot;
    exp_q[intf].push_back(want);
    @(posedge clk);
    hash_valid[intf]  <= 1'b1;
    hash[intf].value  <= value;
    @(negedge clk);
    while (!hash_ready[intf]) begin
      @(negedge clk);
    end
    @(posedge clk);
    hash_valid[intf] <= 1'b0;
  endtask

  task automatic wait_drain();
    int pending;
    do begin
      @(posedge clk);
      pending = 0;
      for (int i = 0; i < INTERFACE_COUNT; i++) begin
        pending += exp_q[i].size();
      end
    end while (pending != 0);
  endtask

  task automatic run_step(input step_t st);
    case (st.op)
      OP_WR: begin
        apb_write(st.addr, st.data);
      end
      OP_RD: begin
        for (int r = 0; r < int'(st.rep); r++) begin
          apb_read_check(st.addr + 8'(4 * r), st.data);
        end
      end
      OP_CTRL: begin
        send_ctrl(st.msg, st.src, st.slot);
      end
      OP_HASH: begin
        send_hash(st.intf, st.data, st.src, st.slot, st.drop);
      end
      default: begin
        wait_drain();
      end
    endcase
  endtask

  initial begin
    repeat (5) @(posedge clk);
    rst_r <= 1'b0;
    for (int s = 0; s < NUM_STEPS; s++) begin
      run_step(STEPS[s]);
    end
    wait_drain();
    // Idle a while so a stray descriptor would still show up
    repeat (20) @(posedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

// File: rx_scheduler.f
source/sched_pkg.sv
source/sched_fifo.sv
source/ctrl_msg_decoder.sv
source/slot_keeper.sv
source/rx_desc_allocator.sv
source/sched_status_apb.sv
source/rx_scheduler.sv
dv/rx_scheduler_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rx_scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module rx_scheduler_tb \
  -f rx_scheduler.f \
  -Mdir "$BUILD_DIR" -o rx_scheduler_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/rx_scheduler_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
exit 1
